// File: Makefile
# Verilator build for the CNN receiver

TOOL     = verilator
FLAGS    = --timing
TOP      = tb_cnn_receiver
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the log holds the pass line
sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
src/cnn_rx_pkg.sv
src/rx_sequencer.sv
src/pool_datapath.sv
src/class_argmax.sv
src/cnn_receiver.sv
test/tb_clock.sv
test/tb_cnn_receiver.sv

// File: src/class_argmax.sv
// Class scores and argmax pipeline
`timescale 1ns/1ns
`default_nettype none

module class_argmax
(
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  score_we_i,
    input  wire  [cnn_rx_pkg::CLASS_W-1:0]       score_idx_i,
    input  wire  [cnn_rx_pkg::ACC_W-1:0]         mac_accum_i,
    input  wire  [cnn_rx_pkg::DATA_W-1:0]        bias_q_i,
    input  wire                                  classify_start_i,
    output logic [cnn_rx_pkg::CLASS_W-1:0]       digit_o,
    output logic                                 digit_valid_o
);

    typedef logic [cnn_rx_pkg::CLASS_W-1:0] idx_t;

    logic signed [cnn_rx_pkg::DATA_W-1:0] score_q [0:cnn_rx_pkg::NUM_CLASSES-1];

    // Registered start, so the result lands five edges after the tenth score
    logic start_q;

    // Stage 1, pairwise winners
    idx_t w01_q, w23_q, w45_q, w67_q, w89_q;
    logic v1_q;
    // Stage 2
    idx_t w03_q, w47_q, w89_s2_q;
    logic v2_q;
    // Stage 3
    idx_t w07_q, w89_s3_q;
    logic v3_q;

    // Strict compare, ties go to b which holds the higher index
    function automatic idx_t pick(input logic signed [cnn_rx_pkg::DATA_W-1:0] a_val,
                                  input logic signed [cnn_rx_pkg::DATA_W-1:0] b_val,
                                  input idx_t a_idx,
                                  input idx_t b_idx);
        begin
            pick = (a_val > b_val) ? a_idx : b_idx;
        end
    endfunction

    // Score store, wrapping 16-bit sum
    always_ff @(posedge clk)
    begin
        if (score_we_i)
        begin
            score_q[score_idx_i] <= mac_accum_i[cnn_rx_pkg::DATA_W-1:0] + bias_q_i;
        end
    end

    // Valid bits through the tree
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            start_q       <= 1'b0;
            v1_q          <= 1'b0;
            v2_q          <= 1'b0;
            v3_q          <= 1'b0;
            digit_valid_o <= 1'b0;
        end
        else
        begin
            start_q       <= classify_start_i;
            v1_q          <= start_q;
            v2_q          <= v1_q;
            v3_q          <= v2_q;
            digit_valid_o <= v3_q;
        end
    end

    // Winner indices, pair 8/9 rides along until stage 4
    always_ff @(posedge clk)
    begin
        w01_q <= pick(score_q[0], score_q[1], idx_t'(0), idx_t'(1));
        w23_q <= pick(score_q[2], score_q[3], idx_t'(2), idx_t'(3));
        w45_q <= pick(score_q[4], score_q[5], idx_t'(4), idx_t'(5));
        w67_q <= pick(score_q[6], score_q[7], idx_t'(6), idx_t'(7));
        w89_q <= pick(score_q[8], score_q[9], idx_t'(8), idx_t'(9));

        w03_q    <= pick(score_q[w01_q], score_q[w23_q], w01_q, w23_q);
        w47_q    <= pick(score_q[w45_q], score_q[w67_q], w45_q, w67_q);
        w89_s2_q <= w89_q;

        w07_q    <= pick(score_q[w03_q], score_q[w47_q], w03_q, w47_q);
        w89_s3_q <= w89_s2_q;

        digit_o <= pick(score_q[w07_q], score_q[w89_s3_q], w07_q, w89_s3_q);
    end

endmodule

`default_nettype wire

// File: src/cnn_receiver.sv
// CNN receiver top level
`timescale 1ns/1ns
`default_nettype none

module cnn_receiver
(
    input  wire                                  clk,
    input  wire                                  rst,

    // MAC array results
    input  wire                                  mac_valid_i,
    input  wire  [cnn_rx_pkg::ACC_W-1:0]         mac_accum_i,
    output logic                                 conv_layer_o,

    // Bias memory, read combinationally
    output logic [cnn_rx_pkg::BIAS_ADDR_W-1:0]   bias_addr_o,
    input  wire  [cnn_rx_pkg::DATA_W-1:0]        bias_q_i,

    // Pooled feature map writes
    output logic                                 fmap_wr_en_o,
    output logic [cnn_rx_pkg::POOL_ADDR_W-1:0]   fmap_wr_addr_o,
    output logic [cnn_rx_pkg::DATA_W-1:0]        fmap_wr_data_o,

    // Classified digit
    output logic [cnn_rx_pkg::CLASS_W-1:0]       digit_o,
    output logic                                 digit_valid_o
);

    logic                               conv_sample;
    logic                               window_done;
    logic [cnn_rx_pkg::POOL_ADDR_W-1:0] pool_addr;
    logic                               score_we;
    logic [cnn_rx_pkg::CLASS_W-1:0]     score_idx;
    logic                               classify_start;

    rx_sequencer i_sequencer
    (
        .clk              (clk),
        .rst              (rst),
        .mac_valid_i      (mac_valid_i),
        .bias_addr_o      (bias_addr_o),
        .conv_layer_o     (conv_layer_o),
        .conv_sample_o    (conv_sample),
        .window_done_o    (window_done),
        .pool_addr_o      (pool_addr),
        .score_we_o       (score_we),
        .score_idx_o      (score_idx),
        .classify_start_o (classify_start)
    );

    pool_datapath i_pool
    (
        .clk            (clk),
        .rst            (rst),
        .conv_sample_i  (conv_sample),
        .window_done_i  (window_done),
        .pool_addr_i    (pool_addr),
        .mac_accum_i    (mac_accum_i),
        .bias_q_i       (bias_q_i),
        .fmap_wr_en_o   (fmap_wr_en_o),
        .fmap_wr_addr_o (fmap_wr_addr_o),
        .fmap_wr_data_o (fmap_wr_data_o)
    );

    class_argmax i_argmax
    (
        .clk              (clk),
        .rst              (rst),
        .score_we_i       (score_we),
        .score_idx_i      (score_idx),
        .mac_accum_i      (mac_accum_i),
        .bias_q_i         (bias_q_i),
        .classify_start_i (classify_start),
        .digit_o          (digit_o),
        .digit_valid_o    (digit_valid_o)
    );

endmodule

`default_nettype wire

// File: src/cnn_rx_pkg.sv
// CNN receiver definitions
`default_nettype none

package cnn_rx_pkg;

    // Datapath widths
    localparam int DATA_W = 16;
    localparam int ACC_W  = 18;

    // Convolution output map, pooled down by two in each direction
    localparam int IMG_W       = 8;
    localparam int IMG_H       = 8;
    localparam int POOL_N      = (IMG_W / 2) * (IMG_H / 2);
    localparam int POOL_ADDR_W = $clog2(POOL_N);

    // Classification layer
    localparam int NUM_CLASSES = 10;
    localparam int CLASS_W     = $clog2(NUM_CLASSES);

    // Bias memory map
    localparam int BIAS_ADDR_W = 4;
    localparam logic [BIAS_ADDR_W-1:0] CONV_BIAS_ADDR  = 4'd0;
    // Class k reads its bias at base + k
    localparam logic [BIAS_ADDR_W-1:0] CLASS_BIAS_BASE = 4'd1;

    // Receiver layer states
    typedef enum logic [1:0]
    {
        CONV_PROCESS = 2'd0,
        FC_PROCESS   = 2'd1,
        CLASSIFY     = 2'd2
    } rx_state_e;

endpackage

`default_nettype wire

// File: src/pool_datapath.sv
// Bias, ReLU and average pooling
`timescale 1ns/1ns
`default_nettype none

module pool_datapath
(
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  conv_sample_i,
    input  wire                                  window_done_i,
    input  wire  [cnn_rx_pkg::POOL_ADDR_W-1:0]   pool_addr_i,
    input  wire  [cnn_rx_pkg::ACC_W-1:0]         mac_accum_i,
    input  wire  [cnn_rx_pkg::DATA_W-1:0]        bias_q_i,
    output logic                                 fmap_wr_en_o,
    output logic [cnn_rx_pkg::POOL_ADDR_W-1:0]   fmap_wr_addr_o,
    output logic [cnn_rx_pkg::DATA_W-1:0]        fmap_wr_data_o
);

    localparam int SUM_W = cnn_rx_pkg::DATA_W + 2;

    // Entry 0 holds the newest pixel, entry IMG_W the oldest
    logic [cnn_rx_pkg::DATA_W-1:0] line_q [0:cnn_rx_pkg::IMG_W];

    logic [cnn_rx_pkg::DATA_W-1:0] biased;
    logic [cnn_rx_pkg::DATA_W-1:0] pixel;
    logic [SUM_W-1:0]              pool_sum;
    logic [cnn_rx_pkg::DATA_W-1:0] pool_avg;

    // Low half of the MAC result plus bias, wrapping
    assign biased = mac_accum_i[cnn_rx_pkg::DATA_W-1:0] + bias_q_i;

    // ReLU on the sign bit
    always_comb
    begin
        if (biased[cnn_rx_pkg::DATA_W-1])
        begin
            pixel = '0;
        end
        else
        begin
            pixel = biased;
        end
    end

    // 2x2 window: current, left, above, above-left
    assign pool_sum = SUM_W'(pixel)
                    + SUM_W'(line_q[0])
                    + SUM_W'(line_q[cnn_rx_pkg::IMG_W-1])
                    + SUM_W'(line_q[cnn_rx_pkg::IMG_W]);

    // Divide by four
    assign pool_avg = pool_sum[SUM_W-1:2];

    // Line buffer shifts once per convolution sample
    always_ff @(posedge clk)
    begin
        if (conv_sample_i)
        begin
            line_q[0] <= pixel;
            for (int i = 1; i <= cnn_rx_pkg::IMG_W; i++)
            begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // Write strobe
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            fmap_wr_en_o <= 1'b0;
        end
        else
        begin
            fmap_wr_en_o <= window_done_i;
        end
    end

    // Write address and data, captured with the window's last pixel
    always_ff @(posedge clk)
    begin
        if (window_done_i)
        begin
            fmap_wr_addr_o <= pool_addr_i;
            fmap_wr_data_o <= pool_avg;
        end
    end

endmodule

`default_nettype wire

// File: src/rx_sequencer.sv
// Receiver layer sequencer
`timescale 1ns/1ns
`default_nettype none

module rx_sequencer
(
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  mac_valid_i,
    output logic [cnn_rx_pkg::BIAS_ADDR_W-1:0]   bias_addr_o,
    output logic                                 conv_layer_o,
    output logic                                 conv_sample_o,
    output logic                                 window_done_o,
    output logic [cnn_rx_pkg::POOL_ADDR_W-1:0]   pool_addr_o,
    output logic                                 score_we_o,
    output logic [cnn_rx_pkg::CLASS_W-1:0]       score_idx_o,
    output logic                                 classify_start_o
);

    localparam int X_W = $clog2(cnn_rx_pkg::IMG_W);
    localparam int Y_W = $clog2(cnn_rx_pkg::IMG_H);

    cnn_rx_pkg::rx_state_e state_q;

    // Position in the convolution output map
    logic [X_W-1:0] x_q;
    logic [Y_W-1:0] y_q;

    // Current class in the classification layer
    logic [cnn_rx_pkg::CLASS_W-1:0] class_q;

    logic last_x;
    logic last_y;
    logic last_class;

    assign last_x     = (x_q == X_W'(cnn_rx_pkg::IMG_W - 1));
    assign last_y     = (y_q == Y_W'(cnn_rx_pkg::IMG_H - 1));
    assign last_class = (class_q == cnn_rx_pkg::CLASS_W'(cnn_rx_pkg::NUM_CLASSES - 1));

    // Layer decode towards the MAC array and the two datapaths
    assign conv_layer_o     = (state_q == cnn_rx_pkg::CONV_PROCESS);
    assign conv_sample_o    = mac_valid_i && (state_q == cnn_rx_pkg::CONV_PROCESS);
    assign window_done_o    = conv_sample_o && x_q[0] && y_q[0];
    assign score_we_o       = mac_valid_i && (state_q == cnn_rx_pkg::FC_PROCESS);
    assign score_idx_o      = class_q;
    assign classify_start_o = (state_q == cnn_rx_pkg::CLASSIFY);

    // Pooled index is (y/2)*4 + x/2
    assign pool_addr_o = {y_q[Y_W-1:1], x_q[X_W-1:1]};

    // Bias word follows the layer and, in FC, the class
    always_comb
    begin
        if (state_q == cnn_rx_pkg::FC_PROCESS)
        begin
            bias_addr_o = cnn_rx_pkg::CLASS_BIAS_BASE + class_q;
        end
        else
        begin
            bias_addr_o = cnn_rx_pkg::CONV_BIAS_ADDR;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state_q <= cnn_rx_pkg::CONV_PROCESS;
            x_q     <= '0;
            y_q     <= '0;
            class_q <= '0;
        end
        else
        begin
            case (state_q)
                cnn_rx_pkg::CONV_PROCESS:
                begin
                    // Raster order, the 64th sample closes the layer
                    if (mac_valid_i)
                    begin
                        if (last_x)
                        begin
                            x_q <= '0;
                            if (last_y)
                            begin
                                y_q     <= '0;
                                state_q <= cnn_rx_pkg::FC_PROCESS;
                            end
                            else
                            begin
                                y_q <= y_q + 1'b1;
                            end
                        end
                        else
                        begin
                            x_q <= x_q + 1'b1;
                        end
                    end
                end

                cnn_rx_pkg::FC_PROCESS:
                begin
                    if (mac_valid_i)
                    begin
                        if (last_class)
                        begin
                            class_q <= '0;
                            state_q <= cnn_rx_pkg::CLASSIFY;
                        end
                        else
                        begin
                            class_q <= class_q + 1'b1;
                        end
                    end
                end

                cnn_rx_pkg::CLASSIFY:
                begin
                    // Single cycle, input ignored, ready for the next frame
                    state_q <= cnn_rx_pkg::CONV_PROCESS;
                    x_q     <= '0;
                    y_q     <= '0;
                    class_q <= '0;
                end

                default:
                begin
                    state_q <= cnn_rx_pkg::CONV_PROCESS;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
// Testbench clock
`timescale 1ns/1ns
`default_nettype none

module tb_clock
#(
    parameter int PERIOD_NS = 4
)
(
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_cnn_receiver.sv
// CNN receiver testbench
`timescale 1ns/1ns
`default_nettype none

module tb_cnn_receiver;

    localparam int DW           = cnn_rx_pkg::DATA_W;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_FRAMES   = 3;
    localparam int MAX_GAP      = 2;
    localparam int MAP_PIXELS   = cnn_rx_pkg::IMG_W * cnn_rx_pkg::IMG_H;
    localparam int BIAS_DEPTH   = 1 << cnn_rx_pkg::BIAS_ADDR_W;
    // Result is due 5 edges after the tenth score
    localparam int RESULT_EDGES   = 5;
    localparam int RESULT_TIMEOUT = 16;
    localparam int FRAME_CYCLES   =
        (MAP_PIXELS + cnn_rx_pkg::NUM_CLASSES) * (MAX_GAP + 1) + RESULT_TIMEOUT + 2;
    localparam int WATCHDOG_NS    =
        (RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES) * CLK_PERIOD * 2;

    typedef logic [DW-1:0]                          data_t;
    typedef logic [DW+1:0]                          sum_t;
    typedef logic [cnn_rx_pkg::ACC_W-1:0]           acc_t;
    typedef logic [cnn_rx_pkg::POOL_ADDR_W-1:0]     pool_addr_t;
    typedef logic [cnn_rx_pkg::BIAS_ADDR_W-1:0]     bias_addr_t;
    typedef logic [cnn_rx_pkg::CLASS_W-1:0]         class_t;

    logic       clk;
    logic       rst;
    logic       mac_valid;
    acc_t       mac_accum;
    data_t      bias_q;
    bias_addr_t bias_addr;
    logic       conv_layer;
    logic       fmap_wr_en;
    pool_addr_t fmap_wr_addr;
    data_t      fmap_wr_data;
    class_t     digit;
    logic       digit_valid;

    int errors;
    int tests_run;

    // Bias memory contents and the model's ReLU output map
    data_t bias_rom [0:BIAS_DEPTH-1];
    data_t pix_map  [0:cnn_rx_pkg::IMG_H-1][0:cnn_rx_pkg::IMG_W-1];

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) i_clock (.clk_o(clk));

    cnn_receiver i_dut
    (
        .clk            (clk),
        .rst            (rst),
        .mac_valid_i    (mac_valid),
        .mac_accum_i    (mac_accum),
        .conv_layer_o   (conv_layer),
        .bias_addr_o    (bias_addr),
        .bias_q_i       (bias_q),
        .fmap_wr_en_o   (fmap_wr_en),
        .fmap_wr_addr_o (fmap_wr_addr),
        .fmap_wr_data_o (fmap_wr_data),
        .digit_o        (digit),
        .digit_valid_o  (digit_valid)
    );

    // Bias memory answers in the same cycle
    assign bias_q = bias_rom[bias_addr];

    task automatic report_mismatch(input string test_name, input string what,
                                   input int expected, input int actual);
        begin
            $display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    // Conv bias stays small and positive, class biases are signed
    task automatic fill_bias_rom();
        int a;
        begin
            for (a = 0; a < BIAS_DEPTH; a++)
            begin
                bias_rom[a] = data_t'($urandom_range(32'h0FFF, 0));
            end
            for (a = 0; a < cnn_rx_pkg::NUM_CLASSES; a++)
            begin
                bias_rom[int'(cnn_rx_pkg::CLASS_BIAS_BASE) + a] =
                    data_t'($urandom_range(32'h07FF, 0) - 32'h0400);
            end
        end
    endtask

    // Low half plus bias, wrapping, then zero when the sign bit is set
    function automatic data_t expected_pixel(input acc_t accum, input data_t bias);
        data_t sum;
        begin
            sum = accum[DW-1:0] + bias;
            expected_pixel = sum[DW-1] ? data_t'(0) : sum;
        end
    endfunction

    function automatic data_t expected_pool(input int px, input int py);
        sum_t total;
        begin
            total = sum_t'(pix_map[py][px]) + sum_t'(pix_map[py][px-1])
                  + sum_t'(pix_map[py-1][px]) + sum_t'(pix_map[py-1][px-1]);
            expected_pool = total[DW+1:2];
        end
    endfunction

    // Biased sum stays clear of wrapping in either direction
    function automatic acc_t random_accum(input logic negative);
        acc_t value;
        begin
            value = acc_t'($urandom);
            if (negative)
            begin
                value[DW-1 -: 3] = 3'b110;
            end
            else
            begin
                value[DW-1 -: 2] = 2'b00;
            end
            random_accum = value;
        end
    endfunction

    task automatic check_conv_cycle(input string name, input logic in_conv,
                                    input logic wr_expected, input pool_addr_t addr_expected,
                                    input data_t data_expected);
        begin
            if (in_conv && conv_layer !== 1'b1)
                report_mismatch(name, "conv_layer_o", 1, int'(conv_layer));
            if (in_conv && bias_addr !== cnn_rx_pkg::CONV_BIAS_ADDR)
                report_mismatch(name, "bias_addr_o", int'(cnn_rx_pkg::CONV_BIAS_ADDR),
                                int'(bias_addr));
            if (digit_valid !== 1'b0)
                report_mismatch(name, "digit_valid_o", 0, int'(digit_valid));
            if (fmap_wr_en !== wr_expected)
            begin
                report_mismatch(name, "fmap_wr_en_o", int'(wr_expected), int'(fmap_wr_en));
            end
            else if (wr_expected)
            begin
                if (fmap_wr_addr !== addr_expected)
                    report_mismatch(name, "fmap_wr_addr_o", int'(addr_expected),
                                    int'(fmap_wr_addr));
                if (fmap_wr_data !== data_expected)
                    report_mismatch(name, "fmap_wr_data_o", int'(data_expected),
                                    int'(fmap_wr_data));
            end
        end
    endtask

    task automatic check_fc_cycle(input string name, input int k);
        bias_addr_t addr_expected;
        begin
            addr_expected = bias_addr_t'(int'(cnn_rx_pkg::CLASS_BIAS_BASE) + k);
            if (conv_layer !== 1'b0)
                report_mismatch(name, "conv_layer_o", 0, int'(conv_layer));
            if (bias_addr !== addr_expected)
                report_mismatch(name, "bias_addr_o", int'(addr_expected), int'(bias_addr));
            if (fmap_wr_en !== 1'b0)
                report_mismatch(name, "fmap_wr_en_o", 0, int'(fmap_wr_en));
            if (digit_valid !== 1'b0)
                report_mismatch(name, "digit_valid_o", 0, int'(digit_valid));
        end
    endtask

    task automatic run_reset_test(input string name);
        begin
            tests_run++;
            rst       = 1'b1;
            mac_valid = 1'b0;
            repeat (RESET_CYCLES) @(negedge clk);
            if (fmap_wr_en !== 1'b0)
                report_mismatch(name, "fmap_wr_en_o", 0, int'(fmap_wr_en));
            if (digit_valid !== 1'b0)
                report_mismatch(name, "digit_valid_o", 0, int'(digit_valid));
            if (conv_layer !== 1'b1)
                report_mismatch(name, "conv_layer_o", 1, int'(conv_layer));
            if (bias_addr !== cnn_rx_pkg::CONV_BIAS_ADDR)
                report_mismatch(name, "bias_addr_o", int'(cnn_rx_pkg::CONV_BIAS_ADDR),
                                int'(bias_addr));
            rst = 1'b0;
        end
    endtask

    // One 8x8 map in raster order, optional idle cycles before each sample
    task automatic run_conv_frame(input string name, input int neg_pct, input int max_gap);
        int         px;
        int         py;
        int         gap;
        int         writes_seen;
        logic       pend;
        pool_addr_t pend_addr;
        data_t      pend_data;
        acc_t       accum;
        begin
            tests_run++;
            writes_seen = 0;
            pend        = 1'b0;
            pend_addr   = '0;
            pend_data   = '0;
            for (py = 0; py < cnn_rx_pkg::IMG_H; py++)
            begin
                for (px = 0; px < cnn_rx_pkg::IMG_W; px++)
                begin
                    gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
                    repeat (gap)
                    begin
                        if (fmap_wr_en === 1'b1)
                            writes_seen++;
                        check_conv_cycle(name, 1'b1, pend, pend_addr, pend_data);
                        pend      = 1'b0;
                        mac_valid = 1'b0;
                        mac_accum = acc_t'($urandom);
                        @(negedge clk);
                    end
                    if (fmap_wr_en === 1'b1)
                        writes_seen++;
                    check_conv_cycle(name, 1'b1, pend, pend_addr, pend_data);
                    pend  = 1'b0;
                    accum = random_accum(int'($urandom_range(99, 0)) < neg_pct);
                    pix_map[py][px] = expected_pixel(accum, bias_rom[cnn_rx_pkg::CONV_BIAS_ADDR]);
                    // Last pixel of a 2x2 window
                    if ((px % 2 == 1) && (py % 2 == 1))
                    begin
                        pend      = 1'b1;
                        pend_addr = pool_addr_t'((py / 2) * (cnn_rx_pkg::IMG_W / 2) + px / 2);
                        pend_data = expected_pool(px, py);
                    end
                    mac_valid = 1'b1;
                    mac_accum = accum;
                    @(negedge clk);
                end
            end
            // Final write lands after the layer has moved on
            if (fmap_wr_en === 1'b1)
                writes_seen++;
            check_conv_cycle(name, 1'b0, pend, pend_addr, pend_data);
            mac_valid = 1'b0;
            @(negedge clk);
            if (writes_seen != cnn_rx_pkg::POOL_N)
                report_mismatch(name, "write count", cnn_rx_pkg::POOL_N, writes_seen);
        end
    endtask

    // Ten distinct signed scores, then wait for the digit
    task automatic run_classify(input string name, input int max_gap);
        logic signed [DW-1:0] scores [0:cnn_rx_pkg::NUM_CLASSES-1];
        int    k;
        int    j;
        int    gap;
        int    best;
        int    edges;
        logic  dup;
        data_t low;
        begin
            tests_run++;
            for (k = 0; k < cnn_rx_pkg::NUM_CLASSES; k++)
            begin
                dup = 1'b1;
                while (dup)
                begin
                    scores[k] = data_t'($urandom_range(32'h3FFF, 0) - 32'h2000);
                    dup = 1'b0;
                    for (j = 0; j < k; j++)
                    begin
                        if (scores[j] == scores[k])
                            dup = 1'b1;
                    end
                end
            end
            best = 0;
            for (k = 1; k < cnn_rx_pkg::NUM_CLASSES; k++)
            begin
                if (scores[k] > scores[best])
                    best = k;
            end
            for (k = 0; k < cnn_rx_pkg::NUM_CLASSES; k++)
            begin
                gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
                repeat (gap)
                begin
                    check_fc_cycle(name, k);
                    mac_valid = 1'b0;
                    mac_accum = acc_t'($urandom);
                    @(negedge clk);
                end
                check_fc_cycle(name, k);
                // MAC value that gives the wanted score after the bias
                low       = scores[k] - bias_rom[int'(cnn_rx_pkg::CLASS_BIAS_BASE) + k];
                mac_valid = 1'b1;
                mac_accum = {2'($urandom), low};
                @(negedge clk);
            end
            // A sample during the single classify cycle must be dropped
            mac_valid = 1'b1;
            mac_accum = acc_t'($urandom);
            @(negedge clk);
            edges     = 1;
            mac_valid = 1'b0;
            if (conv_layer !== 1'b1)
                report_mismatch(name, "conv_layer_o", 1, int'(conv_layer));
            while (digit_valid !== 1'b1 && edges < RESULT_TIMEOUT)
            begin
                @(negedge clk);
                edges++;
            end
            if (digit_valid !== 1'b1)
            begin
                $display("%s: digit_valid_o did not rise within %0d cycles", name, edges);
                errors++;
            end
            else
            begin
                if (edges != RESULT_EDGES)
                    report_mismatch(name, "digit latency", RESULT_EDGES, edges);
                if (digit !== class_t'(best))
                    report_mismatch(name, "digit_o", best, int'(digit));
                @(negedge clk);
                if (digit_valid !== 1'b0)
                    report_mismatch(name, "digit_valid_o pulse end", 0, int'(digit_valid));
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'he6de_a385));
        errors    = 0;
        tests_run = 0;
        rst       = 1'b1;
        mac_valid = 1'b0;
        mac_accum = '0;
        fill_bias_rom();

        run_reset_test("reset");
        run_conv_frame("conv_positive", 0, 0);
        run_classify("classify_first", 0);
        run_conv_frame("conv_relu_gaps", 30, MAX_GAP);
        run_classify("classify_gaps", MAX_GAP);
        run_conv_frame("conv_third_frame", 10, MAX_GAP);
        run_classify("classify_third", 1);

        $display("Summary: %0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    // Bound on the whole run, sized from the frame lengths with margin
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
